//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tbRvCore -o simTbRvCore
./obj_dir/simTbRvCore | tee sim.log

if grep -q "All tests passed!" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- rvAlu.sv
`timescale 1ns/1ns

module rvAlu import rvCtrlPkg::*; (
	input  logic [31:0] srcA,
	input  logic [31:0] srcB,
	input  aluOpT       aluOp,
	output logic [31:0] result,
	output logic        zero
);

	logic [4:0] shamt;

	assign shamt = srcB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd:   result = srcA + srcB;
			aluSub:   result = srcA - srcB;
			aluSll:   result = srcA << shamt;
			aluSlt:   result = {31'b0, $signed(srcA) < $signed(srcB)};
			aluSltu:  result = {31'b0, srcA < srcB};
			aluXor:   result = srcA ^ srcB;
			aluSrl:   result = srcA >> shamt;
			aluSra:   result = $signed(srcA) >>> shamt;
			aluOr:    result = srcA | srcB;
			aluAnd:   result = srcA & srcB;
			aluPassB: result = srcB;
			default:  result = '0;
		endcase
	end

	// beq looks at this after aluSub
	assign zero = (result == 32'b0);

endmodule

//--- rvCore.sv
`timescale 1ns/1ns

module rvCore import rvIsaPkg::*, rvCtrlPkg::*; #(
	parameter logic [xlen-1:0] resetPc = '0
) (
	input  logic            clk,
	input  logic            rstN,
	input  logic [xlen-1:0] inst,
	input  logic [xlen-1:0] readData,  // aligned to bit 0, zero above access
	output logic [xlen-1:0] pc,
	output logic [xlen-1:0] aluResult, // also the data address
	output logic [xlen-1:0] storeData,
	output memSizeT         dataLen,
	output logic            memWrite,
	output wbSelT           memToReg,
	output logic            invalid,
	output logic            halt
);

	aluOpT           aluOp;
	pcSelT           pcSel;
	wbSelT           wbSel;
	regIdxT          rs1Idx, rs2Idx, rdIdx;
	logic            aluSrcImm, isBranch, loadSigned, ebreak, zero;
	logic            decRegWrite, decMemWrite, regWrite;
	logic [xlen-1:0] imm, rdData1, rdData2, srcB;
	logic [xlen-1:0] pcPlus4, pcImm, loadData, wrData;

	assign rs1Idx = inst[19:15];
	assign rs2Idx = inst[24:20];
	assign rdIdx  = inst[11:7];

	assign srcB      = aluSrcImm ? imm : rdData2;
	assign storeData = rdData2; // memory does the lane placement
	assign memToReg  = wbSel;

	// nothing retires while halted
	assign regWrite = decRegWrite & ~halt;
	assign memWrite = decMemWrite & ~halt;

	always_comb begin
		loadData = readData;
		if (loadSigned) begin
			case (dataLen)
				sizeByte: loadData = {{24{readData[7]}}, readData[7:0]};
				sizeHalf: loadData = {{16{readData[15]}}, readData[15:0]};
				default:  loadData = readData;
			endcase
		end
	end

	always_comb begin
		case (wbSel)
			wbMem:     wrData = loadData;
			wbPcPlus4: wrData = pcPlus4; // link
			wbPcImm:   wrData = pcImm;
			default:   wrData = aluResult;
		endcase
	end

	rvDecoder decoder_i (
		.inst(inst), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .pcSel(pcSel),
		.isBranch(isBranch), .regWrite(decRegWrite), .memWrite(decMemWrite),
		.wbSel(wbSel), .dataLen(dataLen), .loadSigned(loadSigned), .imm(imm),
		.invalid(invalid), .ebreak(ebreak)
	);

	rvRegFile regFile_i (
		.clk(clk), .rstN(rstN), .rs1(rs1Idx), .rs2(rs2Idx), .rd(rdIdx),
		.wrEn(regWrite), .wrData(wrData), .rdData1(rdData1), .rdData2(rdData2)
	);

	rvAlu alu_i (
		.srcA(rdData1), .srcB(srcB), .aluOp(aluOp), .result(aluResult), .zero(zero)
	);

	rvFetch #(.resetPc(resetPc)) fetch_i (
		.clk(clk), .rstN(rstN), .imm(imm), .aluResult(aluResult), .zero(zero),
		.pcSel(pcSel), .isBranch(isBranch), .ebreak(ebreak), .pc(pc),
		.pcPlus4(pcPlus4), .pcImm(pcImm), .halt(halt)
	);

endmodule

//--- rvCtrlPkg.sv
package rvCtrlPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB // lui
	} aluOpT;

	// next pc source
	typedef enum logic [1:0] {
		pcPlus4,
		pcBranch, // pc+imm, conditional when isBranch
		pcJalr
	} pcSelT;

	// write-back source, also seen outside as memToReg
	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbPcPlus4,
		wbPcImm // auipc
	} wbSelT;

	// access size, same codes as the memory side expects
	typedef enum logic [1:0] {
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd3
	} memSizeT;

endpackage

//--- rvDecoder.sv
`timescale 1ns/1ns

module rvDecoder import rvIsaPkg::*, rvCtrlPkg::*; (
	input  logic [xlen-1:0] inst,
	output aluOpT           aluOp,
	output logic            aluSrcImm,
	output pcSelT           pcSel,
	output logic            isBranch,
	output logic            regWrite,
	output logic            memWrite,
	output wbSelT           wbSel,
	output memSizeT         dataLen,
	output logic            loadSigned,
	output logic [xlen-1:0] imm,
	output logic            invalid,
	output logic            ebreak
);

	opcodeT          opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] immI, immS, immB, immU, immJ;
	logic            valid;

	function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt);
		aluOpT op;
		case (f3)
			f3AddSub: op = alt ? aluSub : aluAdd;
			f3Sll:    op = aluSll;
			f3Slt:    op = aluSlt;
			f3Sltu:   op = aluSltu;
			f3Xor:    op = aluXor;
			f3SrlSra: op = alt ? aluSra : aluSrl;
			f3Or:     op = aluOr;
			f3And:    op = aluAnd;
			default:  op = aluAdd;
		endcase
		return op;
	endfunction

	assign opcode = opcodeT'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		aluOp      = aluAdd;
		aluSrcImm  = 1'b0;
		pcSel      = pcPlus4;
		isBranch   = 1'b0;
		regWrite   = 1'b0;
		memWrite   = 1'b0;
		wbSel      = wbAlu;
		dataLen    = sizeWord;
		loadSigned = ~funct3[2]; // lbu/lhu have bit 2 set
		imm        = immI;
		valid      = 1'b0;
		ebreak     = 1'b0;
		case (opcode)
			opLui: begin
				valid     = 1'b1;
				regWrite  = 1'b1;
				aluSrcImm = 1'b1;
				aluOp     = aluPassB;
				imm       = immU;
			end
			opAuipc: begin
				valid    = 1'b1;
				regWrite = 1'b1;
				wbSel    = wbPcImm; // pc+imm from fetch
				imm      = immU;
			end
			opJal: begin
				valid    = 1'b1;
				regWrite = 1'b1;
				wbSel    = wbPcPlus4;
				pcSel    = pcBranch; // unconditional, isBranch low
				imm      = immJ;
			end
			opJalr: begin
				valid     = (funct3 == f3Jalr);
				regWrite  = 1'b1;
				wbSel     = wbPcPlus4;
				aluSrcImm = 1'b1;
				pcSel     = pcJalr;
			end
			opBranch: begin
				valid    = (funct3 == f3Beq); // only beq
				isBranch = 1'b1;
				pcSel    = pcBranch;
				aluOp    = aluSub;
				imm      = immB;
			end
			opLoad: begin
				regWrite  = 1'b1;
				aluSrcImm = 1'b1;
				wbSel     = wbMem;
				case (funct3)
					f3Byte, f3ByteU: begin
						valid   = 1'b1;
						dataLen = sizeByte;
					end
					f3Half, f3HalfU: begin
						valid   = 1'b1;
						dataLen = sizeHalf;
					end
					f3Word: valid = 1'b1;
					default: valid = 1'b0;
				endcase
			end
			opStore: begin
				memWrite  = 1'b1;
				aluSrcImm = 1'b1;
				imm       = immS;
				case (funct3)
					f3Byte: begin
						valid   = 1'b1;
						dataLen = sizeByte;
					end
					f3Half: begin
						valid   = 1'b1;
						dataLen = sizeHalf;
					end
					f3Word: valid = 1'b1;
					default: valid = 1'b0;
				endcase
			end
			opOpImm: begin
				// shift-immediates not supported
				valid     = (funct3 != f3Sll) && (funct3 != f3SrlSra);
				regWrite  = 1'b1;
				aluSrcImm = 1'b1;
				aluOp     = aluFromFunct3(funct3, 1'b0);
			end
			opOp: begin
				valid = (funct7 == f7Base) ||
					((funct7 == f7Alt) && (funct3 == f3AddSub || funct3 == f3SrlSra));
				regWrite = 1'b1;
				aluOp    = aluFromFunct3(funct3, funct7 == f7Alt);
			end
			opSystem: begin
				valid  = (inst == ebreakWord);
				ebreak = valid;
			end
			default: valid = 1'b0;
		endcase

		// unsupported encoding: no writes, just step over it
		if (!valid) begin
			regWrite = 1'b0;
			memWrite = 1'b0;
			pcSel    = pcPlus4;
		end
		invalid = ~valid;
	end

endmodule

//--- rvFetch.sv
`timescale 1ns/1ns

module rvFetch import rvCtrlPkg::*; #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] imm,
	input  logic [31:0] aluResult,
	input  logic        zero,
	input  pcSelT       pcSel,
	input  logic        isBranch,
	input  logic        ebreak,
	output logic [31:0] pc,
	output logic [31:0] pcPlus4,
	output logic [31:0] pcImm,
	output logic        halt
);

	logic        halted;
	logic        takeImm;
	logic [31:0] pcNext;

	assign pcPlus4 = pc + 32'd4;
	assign pcImm   = pc + imm;
	assign takeImm = ~isBranch | zero; // jal always takes it
	assign halt    = halted | ebreak;  // up in the ebreak cycle already

	always_comb begin
		case (pcSel)
			pcBranch: pcNext = takeImm ? pcImm : pcPlus4;
			pcJalr:   pcNext = {aluResult[31:1], 1'b0};
			default:  pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc     <= resetPc;
			halted <= 1'b0;
		end else begin
			if (ebreak)
				halted <= 1'b1; // sticky until reset
			if (!halt)
				pc <= pcNext;
		end
	end

endmodule

//--- rvIsaPkg.sv
package rvIsaPkg;

	localparam int xlen = 32;

	typedef logic [4:0] regIdxT;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opOpImm  = 7'b0010011,
		opOp     = 7'b0110011,
		opSystem = 7'b1110011
	} opcodeT;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// funct3 for loads and stores
	localparam logic [2:0] f3Byte  = 3'b000;
	localparam logic [2:0] f3Half  = 3'b001;
	localparam logic [2:0] f3Word  = 3'b010;
	localparam logic [2:0] f3ByteU = 3'b100;
	localparam logic [2:0] f3HalfU = 3'b101;

	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Jalr = 3'b000;

	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt  = 7'b0100000; // sub, sra

	localparam logic [31:0] ebreakWord = 32'h0010_0073;

endpackage

//--- rvRegFile.sv
`timescale 1ns/1ns

module rvRegFile import rvIsaPkg::*; (
	input  logic            clk,
	input  logic            rstN,
	input  regIdxT          rs1,
	input  regIdxT          rs2,
	input  regIdxT          rd,
	input  logic            wrEn,
	input  logic [xlen-1:0] wrData,
	output logic [xlen-1:0] rdData1,
	output logic [xlen-1:0] rdData2
);

	logic [xlen-1:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (rd != '0)) begin
			regs[rd] <= wrData;
		end
	end

	assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- tbRvCore.sv
`timescale 1ns/1ns

module tbRvCore import rvIsaPkg::*, rvCtrlPkg::*; ();

	localparam int clkPeriod   = 4;
	localparam int resetCycles = 10;
	localparam int cycleBudget = 120;
	localparam int watchdogNs  = (5 * (cycleBudget + resetCycles + 2) + 40) * clkPeriod + 400;

	logic        clk, rstN;
	logic [31:0] inst, readData, pc, aluResult, storeData;
	memSizeT     dataLen;
	wbSelT       memToReg;
	logic        memWrite, invalid, halt;

	logic [31:0] rom [256];
	logic [31:0] ram [256];
	logic [4:0]  laneShift;
	logic [31:0] wrMask, rdShifted;

	int          progLen;
	logic [31:0] bodyEnd;
	logic [31:0] lfsrState;
	int          valueErrors = 0;
	int          otherErrors = 0;

	logic [31:0] pcLog [$];
	logic [31:0] invalidLog [$];
	memSizeT     sizeLog [$];
	logic        writeOnInvalid;

	rvCore #(.resetPc(32'h0)) dut_i (
		.clk(clk), .rstN(rstN), .inst(inst), .readData(readData), .pc(pc),
		.aluResult(aluResult), .storeData(storeData), .dataLen(dataLen),
		.memWrite(memWrite), .memToReg(memToReg), .invalid(invalid), .halt(halt)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] fillWord(input logic [7:0] a);
		return {~a, a, a ^ 8'h5a, {a[3:0], a[7:4]} ^ 8'h3c};
	endfunction

	// instruction ROM and byte-lane data RAM
	assign inst      = rom[pc[9:2]];
	assign laneShift = {aluResult[1:0], 3'b000};

	always_comb begin
		rdShifted = ram[aluResult[9:2]] >> laneShift;
		case (dataLen)
			sizeByte: readData = rdShifted & 32'h0000_00ff;
			sizeHalf: readData = rdShifted & 32'h0000_ffff;
			default:  readData = rdShifted;
		endcase
	end

	always_comb begin
		case (dataLen)
			sizeByte: wrMask = 32'h0000_00ff << laneShift;
			sizeHalf: wrMask = 32'h0000_ffff << laneShift;
			default:  wrMask = 32'hffff_ffff;
		endcase
	end

	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 256; i++) begin
				ram[i[7:0]] <= fillWord(i[7:0]);
			end
		end else if (memWrite) begin
			ram[aluResult[9:2]] <= (ram[aluResult[9:2]] & ~wrMask) |
				((storeData << laneShift) & wrMask);
		end
	end

	// traces of the program body, cleared by each reset
	always @(negedge clk) begin
		if (!rstN) begin
			pcLog.delete();
			invalidLog.delete();
			sizeLog.delete();
			writeOnInvalid <= 1'b0;
		end else if (!halt && pc < bodyEnd) begin
			pcLog.push_back(pc);
			if (memWrite || memToReg == wbMem)
				sizeLog.push_back(dataLen);
			if (invalid)
				invalidLog.push_back(pc);
			if (invalid && memWrite)
				writeOnInvalid <= 1'b1;
		end
	end

	initial begin
		#(watchdogNs);
		$display("watchdog expired, the tests did not finish in time");
		$display("Test failures found");
		$finish;
	end

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			r         = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] sext12(input logic [31:0] v);
		return {{20{v[11]}}, v[11:0]};
	endfunction

	// RV32I semantics by funct3, alt selects sub/sra
	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opOp};
	endfunction

	function automatic logic [31:0] encI(input logic [31:0] imm, input int rs1,
			input logic [2:0] f3, input int rd, input opcodeT op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] encS(input logic [31:0] imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] encB(input logic [31:0] imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] encU(input logic [31:0] imm, input int rd, input opcodeT op);
		return {imm[31:12], rd[4:0], op};
	endfunction

	function automatic logic [31:0] encJ(input logic [31:0] imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
	endfunction

	task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR %s expected 0x%08h got 0x%08h", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkSize(input string name, input memSizeT exp, input memSizeT act);
		if (exp !== act) begin
			$display("ERROR %s expected 0x%0h got 0x%0h", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERROR %s expected 0x%0h got 0x%0h", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic compareTrace(input string name, input logic [31:0] exp [$],
			input logic [31:0] act [$]);
		if (exp.size() != act.size()) begin
			$display("%s trace has %0d entries where %0d were expected",
				name, act.size(), exp.size());
			otherErrors++;
		end else begin
			foreach (exp[i]) begin
				checkWord($sformatf("%s[%0d]", name, i), exp[i], act[i]);
			end
		end
	endtask

	// register values land in RAM words 128..159 through the epilogue
	task automatic checkReg(input int n, input logic [31:0] exp);
		logic [7:0] idx;
		idx = 8'd128 + n[7:0];
		checkWord($sformatf("x%0d", n), exp, ram[idx]);
	endtask

	task automatic addInst(input logic [31:0] w);
		rom[progLen[7:0]] = w;
		progLen++;
	endtask

	task automatic emitAddi(input int rd, input int rs1, input logic [31:0] imm);
		addInst(encI(imm, rs1, f3AddSub, rd, opOpImm));
	endtask

	task automatic loadConst(input int rd, input logic [31:0] val);
		logic [31:0] hi;
		hi = val + 32'h800; // addi sign-extends the low part
		addInst(encU(hi, rd, opLui));
		emitAddi(rd, rd, val);
	endtask

	task automatic startProgram();
		for (int i = 0; i < 256; i++) begin
			rom[i[7:0]] = encI(i, 0, f3AddSub, 0, opOpImm); // addi x0 nops
		end
		progLen = 0;
	endtask

	task automatic finishProgram();
		bodyEnd = progLen * 4;
		for (int n = 0; n < 32; n++) begin
			addInst(encS(512 + 4 * n, n, 0, f3Word));
		end
		addInst(ebreakWord);
	endtask

	task automatic pulseReset();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	endtask

	task automatic runProgram(input string name);
		int cycles;
		pulseReset();
		cycles = 0;
		while (!halt && cycles < cycleBudget) begin
			@(negedge clk);
			cycles++;
		end
		if (!halt) begin
			$display("%s program did not reach ebreak within %0d cycles", name, cycleBudget);
			otherErrors++;
		end
	endtask

	task automatic testArith();
		logic [31:0] a, b, luiVal, auiVal, auiPc;
		logic [2:0]  immF3 [6];
		logic [31:0] immVal [6];
		immF3 = '{f3AddSub, f3Slt, f3Sltu, f3Xor, f3Or, f3And};
		a = randBits(32);
		b = randBits(32);
		startProgram();
		loadConst(1, a);
		loadConst(2, b);
		for (int k = 0; k < 8; k++) begin
			addInst(encR(f7Base, 2, 1, k[2:0], 3 + k));
		end
		addInst(encR(f7Alt, 2, 1, f3AddSub, 11));
		addInst(encR(f7Alt, 2, 1, f3SrlSra, 12));
		for (int k = 0; k < 6; k++) begin
			immVal[k] = randBits(12);
			addInst(encI(immVal[k], 1, immF3[k], 13 + k, opOpImm));
		end
		luiVal = randBits(20) << 12;
		addInst(encU(luiVal, 19, opLui));
		auiVal = randBits(20) << 12;
		auiPc  = progLen * 4;
		addInst(encU(auiVal, 20, opAuipc));
		finishProgram();
		runProgram("arithmetic");
		checkReg(1, a);
		checkReg(2, b);
		for (int k = 0; k < 8; k++) begin
			checkReg(3 + k, refAlu(k[2:0], 1'b0, a, b));
		end
		checkReg(11, refAlu(f3AddSub, 1'b1, a, b));
		checkReg(12, refAlu(f3SrlSra, 1'b1, a, b));
		for (int k = 0; k < 6; k++) begin
			checkReg(13 + k, refAlu(immF3[k], 1'b0, a, sext12(immVal[k])));
		end
		checkReg(19, luiVal);
		checkReg(20, auiPc + auiVal);
	endtask

	task automatic testLoadStore();
		logic [31:0] a, w65, w66;
		memSizeT     expSize [$];
		a = randBits(32);
		startProgram();
		loadConst(1, a);
		emitAddi(2, 0, 32'h100); // base, RAM word 64
		loadConst(3, 32'h8cf1_9a7e);
		addInst(encS(0, 1, 2, f3Word));
		addInst(encS(4, 1, 2, f3Byte));
		addInst(encS(7, 1, 2, f3Byte));
		addInst(encS(10, 1, 2, f3Half));
		addInst(encS(12, 3, 2, f3Word));
		addInst(encI(13, 2, f3Byte, 4, opLoad));
		addInst(encI(13, 2, f3ByteU, 5, opLoad));
		addInst(encI(14, 2, f3Half, 6, opLoad));
		addInst(encI(14, 2, f3HalfU, 7, opLoad));
		addInst(encI(12, 2, f3Word, 8, opLoad));
		addInst(encI(12, 2, f3Byte, 9, opLoad));
		addInst(encI(12, 2, f3Half, 10, opLoad));
		addInst(encI(12, 2, f3Word, 0, opLoad)); // x0 must stay zero
		finishProgram();
		runProgram("load/store");
		w65 = fillWord(8'd65);
		w66 = fillWord(8'd66);
		checkWord("ram[64]", a, ram[64]);
		checkWord("ram[65]", {a[7:0], w65[23:8], a[7:0]}, ram[65]);
		checkWord("ram[66]", {a[15:0], w66[15:0]}, ram[66]);
		checkWord("ram[67]", 32'h8cf1_9a7e, ram[67]);
		checkReg(0, 32'h0);
		checkReg(4, 32'hffff_ff9a);
		checkReg(5, 32'h0000_009a);
		checkReg(6, 32'hffff_8cf1);
		checkReg(7, 32'h0000_8cf1);
		checkReg(8, 32'h8cf1_9a7e);
		checkReg(9, 32'h0000_007e);
		checkReg(10, 32'hffff_9a7e);
		expSize = '{sizeWord, sizeByte, sizeByte, sizeHalf, sizeWord, sizeByte, sizeByte,
			sizeHalf, sizeHalf, sizeWord, sizeByte, sizeHalf, sizeWord};
		if (expSize.size() != sizeLog.size()) begin
			$display("saw %0d memory accesses where %0d were expected",
				sizeLog.size(), expSize.size());
			otherErrors++;
		end else begin
			foreach (expSize[i]) begin
				checkSize($sformatf("dataLen[%0d]", i), expSize[i], sizeLog[i]);
			end
		end
	endtask

	task automatic testControl();
		logic [31:0] expPc [$];
		startProgram();
		emitAddi(1, 0, 5);
		emitAddi(2, 0, 5);
		emitAddi(3, 0, 7);
		addInst(encB(8, 2, 1, f3Beq)); // taken to 20
		emitAddi(10, 0, 1);
		addInst(encB(8, 3, 1, f3Beq)); // falls through
		emitAddi(11, 0, 2);
		addInst(encJ(12, 5)); // to 40
		emitAddi(12, 0, 3);
		emitAddi(12, 0, 4);
		emitAddi(6, 0, 57);
		addInst(encI(0, 6, f3Jalr, 7, opJalr)); // 57 -> 56
		emitAddi(13, 0, 5);
		emitAddi(13, 0, 6);
		emitAddi(14, 0, 9);
		finishProgram();
		runProgram("control flow");
		expPc = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd20, 32'd24, 32'd28, 32'd40, 32'd44, 32'd56};
		compareTrace("pc", expPc, pcLog);
		checkReg(5, 32'd32);
		checkReg(7, 32'd48);
		checkReg(10, 32'd0);
		checkReg(11, 32'd2);
		checkReg(12, 32'd0);
		checkReg(13, 32'd0);
		checkReg(14, 32'd9);
	endtask

	task automatic testInvalid();
		logic [31:0] expPc [$];
		logic [31:0] expInv [$];
		startProgram();
		emitAddi(1, 0, 32'h123);
		addInst(encB(8, 0, 1, 3'b001)); // bne
		addInst(encI(0, 0, 3'b011, 2, opLoad));
		addInst(encS(32'h40, 1, 0, 3'b011)); // would hit RAM word 16
		addInst(encR(f7Alt, 1, 1, f3And, 3));
		addInst(encI(3, 1, f3Sll, 4, opOpImm)); // slli
		emitAddi(5, 0, 1);
		finishProgram();
		runProgram("invalid encoding");
		expPc  = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd16, 32'd20, 32'd24};
		expInv = '{32'd4, 32'd8, 32'd12, 32'd16, 32'd20};
		compareTrace("pc", expPc, pcLog);
		compareTrace("invalid pc", expInv, invalidLog);
		checkFlag("memWrite while invalid", 1'b0, writeOnInvalid);
		checkWord("ram[16]", fillWord(8'd16), ram[16]);
		checkReg(1, 32'h123);
		checkReg(2, 32'h0);
		checkReg(3, 32'h0);
		checkReg(4, 32'h0);
		checkReg(5, 32'h1);
	endtask

	task automatic testHalt();
		logic [31:0] bumpWord, storeWord;
		bumpWord  = encI(1, 1, f3AddSub, 1, opOpImm); // addi x1, x1, 1
		storeWord = encS(0, 1, 0, f3Word);
		startProgram();
		emitAddi(1, 0, 1);
		addInst(ebreakWord);
		addInst(storeWord); // never retires
		bodyEnd = 32'd12;
		runProgram("halt");
		checkWord("pc", 32'd4, pc);
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			checkFlag("halt", 1'b1, halt);
			checkWord("pc", 32'd4, pc);
			checkFlag("memWrite", 1'b0, memWrite);
			checkWord("storeData", 32'd1, storeData); // x1 is rs2 of all three words
			// word under the frozen pc replaced, halt now rests on the sticky flag
			rom[1] = (i < 10) ? bumpWord : storeWord;
		end
		checkWord("ram[0]", fillWord(8'd0), ram[0]);
		pulseReset();
		@(negedge clk);
		checkFlag("halt", 1'b0, halt);
		checkWord("pc", 32'd0, pc);
	endtask

	initial begin
		rstN      = 1'b0;
		lfsrState = 32'd32;
		bodyEnd   = '0;
		progLen   = 0;
		testArith();
		testLoadStore();
		testControl();
		testInvalid();
		testHalt();
		$display("%0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- vlog.f
rvIsaPkg.sv
rvCtrlPkg.sv
rvDecoder.sv
rvRegFile.sv
rvAlu.sv
rvFetch.sv
rvCore.sv
tbRvCore.sv
